/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = LarScalarAccessTb
FILELIST = list.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir

/* hdl/LarLineStore.sv */
`timescale 1ns/1ns
`default_nettype none

// line registers, one write port and two combinational read ports
module LarLineStore
#(
	parameter int numLars = 8
)
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [2:0] writeIndex,
	input PkgLarScalar::LarLine writeLine,
	input logic [2:0] mergeIndex,
	output PkgLarScalar::LarLine mergeLine,
	input logic [2:0] readIndex,
	output PkgLarScalar::LarLine readLine
);

	// index bits actually needed for numLars lines
	localparam int IndexWidth = (numLars > 1) ? $clog2(numLars) : 1;

	PkgLarScalar::LarLine lines [numLars];

	logic [IndexWidth-1:0] writeSlot;
	logic [IndexWidth-1:0] mergeSlot;
	logic [IndexWidth-1:0] readSlot;

	// upper index bits are unused with fewer than 8 lines
	assign writeSlot = writeIndex[IndexWidth-1:0];
	assign mergeSlot = mergeIndex[IndexWidth-1:0];
	assign readSlot = readIndex[IndexWidth-1:0];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// all lines start out as zero
			for (int i = 0; i < numLars; i++)
			begin
				lines[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			lines[writeSlot] <= writeLine;
		end
	end

	// old line for the write merge
	assign mergeLine = lines[mergeSlot];

	// a same-cycle read sees the line before the write lands
	assign readLine = lines[readSlot];

endmodule

`default_nettype wire

/* hdl/LarScalarAccess.sv */
`timescale 1ns/1ns
`default_nettype none

// scalar access path into the LAR data file
module LarScalarAccess
#(
	parameter int numLars = 8
)
(
	input logic clk,
	input logic reset,
	input logic writeStrobe,
	input PkgLarScalar::WriteRequest writeReq,
	input logic readStrobe,
	input PkgLarScalar::ScalarAccess readAccess,
	output logic readValid,
	output PkgLarScalar::ScalarData readData
);

	// old line of the LAR being written
	PkgLarScalar::LarLine mergeLine;

	// that line with the new scalar in its lane
	PkgLarScalar::LarLine mergedLine;

	// line of the LAR being read
	PkgLarScalar::LarLine readLine;

	ScalarShifterForWrite i_writeShifter
	(
		.writeReq(writeReq),
		.oldLine(mergeLine),
		.mergedLine(mergedLine)
	);

	// write index and merge index are the same LAR
	LarLineStore
	#(
		.numLars(numLars)
	)
	i_lineStore
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(writeStrobe),
		.writeIndex(writeReq.access.larIndex),
		.writeLine(mergedLine),
		.mergeIndex(writeReq.access.larIndex),
		.mergeLine(mergeLine),
		.readIndex(readAccess.larIndex),
		.readLine(readLine)
	);

	ScalarShifterForRead i_readShifter
	(
		.clk(clk),
		.reset(reset),
		.readStrobe(readStrobe),
		.readAccess(readAccess),
		.line(readLine),
		.readValid(readValid),
		.readData(readData)
	);

endmodule

`default_nettype wire

/* hdl/PkgLarScalar.sv */
`default_nettype none

`include "larWidths.svh"

package PkgLarScalar;

	localparam int LarLineWidth = `LAR_LINE_WIDTH;
	localparam int ScalarWidth = `SCALAR_WIDTH;

	// bit position of a lane, 0 up to 255
	localparam int LaneShiftWidth = $clog2(`LAR_LINE_WIDTH);

	typedef logic [`LAR_LINE_WIDTH-1:0] LarLine;
	typedef logic [`SCALAR_WIDTH-1:0] ScalarData;
	typedef logic [`DATA_OFFSET_WIDTH-1:0] DataOffset;

	typedef enum logic [`DATA_TYPE_WIDTH-1:0]
	{
		UnsgnInt,
		SgnInt,
		BFloat16,
		Reserved
	} DataType;

	// only looked at for the two integer types
	typedef enum logic [`INT_TYPE_SIZE_WIDTH-1:0]
	{
		Sz8,
		Sz16,
		Sz32,
		Sz64
	} IntTypeSize;

	typedef struct packed
	{
		logic [`LAR_INDEX_WIDTH-1:0] larIndex;
		DataType dataType;
		IntTypeSize intTypeSize;
		DataOffset dataOffset;
	} ScalarAccess;

	typedef struct packed
	{
		ScalarAccess access;
		ScalarData scalar;
	} WriteRequest;

	// offset with the bits below the element size cleared, in bits
	function automatic logic [LaneShiftWidth-1:0] laneShift(
		DataType dataType,
		IntTypeSize intTypeSize,
		DataOffset dataOffset);
		DataOffset aligned;
		aligned = dataOffset;
		case (dataType)
			BFloat16:
			begin
				aligned[0] = 1'b0;
			end
			Reserved:
			begin
				// nothing is moved for this type anyway
				aligned = '0;
			end
			default:
			begin
				case (intTypeSize)
					Sz8:
					begin
						aligned = dataOffset;
					end
					Sz16:
					begin
						aligned[0] = 1'b0;
					end
					Sz32:
					begin
						aligned[1:0] = 2'b00;
					end
					default:
					begin
						aligned[2:0] = 3'b000;
					end
				endcase
			end
		endcase
		return {aligned, 3'b000};
	endfunction

	// element-wide mask in the low bits of a scalar
	function automatic ScalarData laneMask(
		DataType dataType,
		IntTypeSize intTypeSize,
		DataOffset dataOffset);
		ScalarData mask;
		mask = '0;
		case (dataType)
			BFloat16:
			begin
				mask = ScalarData'(16'hffff);
			end
			Reserved:
			begin
				mask = '0;
			end
			default:
			begin
				case (intTypeSize)
					Sz8:
					begin
						mask = ScalarData'(8'hff);
					end
					Sz16:
					begin
						mask = ScalarData'(16'hffff);
					end
					Sz32:
					begin
						mask = ScalarData'(32'hffff_ffff);
					end
					default:
					begin
						mask = '1;
					end
				endcase
			end
		endcase
		return mask;
	endfunction

endpackage

`default_nettype wire

/* hdl/ScalarShifterForRead.sv */
`timescale 1ns/1ns
`default_nettype none

// pulls one lane out of a line and registers it, no casting here either
module ScalarShifterForRead
(
	input logic clk,
	input logic reset,
	input logic readStrobe,
	input PkgLarScalar::ScalarAccess readAccess,
	input PkgLarScalar::LarLine line,
	output logic readValid,
	output PkgLarScalar::ScalarData readData
);

	logic [PkgLarScalar::LaneShiftWidth-1:0] shift;
	PkgLarScalar::ScalarData elementMask;

	// lane moved down to bit 0
	PkgLarScalar::LarLine shiftedLine;
	PkgLarScalar::ScalarData lowBits;

	// zero-extended element, ready to register
	PkgLarScalar::ScalarData laneData;

	assign shift = PkgLarScalar::laneShift(
		readAccess.dataType,
		readAccess.intTypeSize,
		readAccess.dataOffset);

	assign elementMask = PkgLarScalar::laneMask(
		readAccess.dataType,
		readAccess.intTypeSize,
		readAccess.dataOffset);

	assign shiftedLine = line >> shift;
	assign lowBits = shiftedLine[PkgLarScalar::ScalarWidth-1:0];

	// mask is zero for reserved, which reads as zero
	assign laneData = lowBits & elementMask;

	// one cycle of latency, one valid pulse per strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readValid <= 1'b0;
			readData <= '0;
		end
		else
		begin
			readValid <= readStrobe;
			if (readStrobe)
			begin
				readData <= laneData;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/ScalarShifterForWrite.sv */
`timescale 1ns/1ns
`default_nettype none

// merges one scalar into a copy of a line, no casting is done here
module ScalarShifterForWrite
(
	input PkgLarScalar::WriteRequest writeReq,
	input PkgLarScalar::LarLine oldLine,
	output PkgLarScalar::LarLine mergedLine
);

	PkgLarScalar::ScalarAccess access;
	PkgLarScalar::ScalarData scalar;

	// lane position and width
	logic [PkgLarScalar::LaneShiftWidth-1:0] shift;
	PkgLarScalar::ScalarData elementMask;

	// mask and data, widened to a full line before shifting
	PkgLarScalar::LarLine wideMask;
	PkgLarScalar::LarLine wideScalar;

	// the same two, moved up to the lane
	PkgLarScalar::LarLine laneBits;
	PkgLarScalar::LarLine laneData;

	// everything outside the lane
	PkgLarScalar::LarLine keptBits;

	assign access = writeReq.access;
	assign scalar = writeReq.scalar;

	assign shift = PkgLarScalar::laneShift(
		access.dataType,
		access.intTypeSize,
		access.dataOffset);

	// zero for the reserved type, so the old line passes unchanged
	assign elementMask = PkgLarScalar::laneMask(
		access.dataType,
		access.intTypeSize,
		access.dataOffset);

	// upper scalar bits beyond the element width are dropped
	assign wideMask = PkgLarScalar::LarLine'(elementMask);
	assign wideScalar = PkgLarScalar::LarLine'(scalar & elementMask);

	assign laneBits = wideMask << shift;
	assign laneData = wideScalar << shift;

	// clear the lane in the old line
	assign keptBits = oldLine & ~laneBits;

	// bfloat16 keeps the low 16 bits of the scalar as they are
	assign mergedLine = keptBits | laneData;

endmodule

`default_nettype wire

/* include/larWidths.svh */
`ifndef LAR_WIDTHS_SVH
`define LAR_WIDTHS_SVH

// one LAR line, the whole data word of a large array register
`define LAR_LINE_WIDTH 256

// widest scalar, narrower ones are zero-extended to this
`define SCALAR_WIDTH 64

// byte offset inside a line
`define DATA_OFFSET_WIDTH 5

// enough for up to 8 LARs
`define LAR_INDEX_WIDTH 3

// type fields of an access
`define DATA_TYPE_WIDTH 2
`define INT_TYPE_SIZE_WIDTH 2

`endif

/* list.f */
+incdir+include
hdl/PkgLarScalar.sv
hdl/ScalarShifterForWrite.sv
hdl/LarLineStore.sv
hdl/ScalarShifterForRead.sv
hdl/LarScalarAccess.sv
sim/LarScalarAccessTb.sv

/* sim/LarScalarAccessTb.sv */
`timescale 1ns/1ns
`default_nettype none

module LarScalarAccessTb;

	localparam int NumRecords = 36;
	localparam int FieldsPerRecord = 7;
	localparam int ClockPeriod = 4;

	// one line of the testdata file
	typedef struct packed
	{
		logic [1:0] op;
		PkgLarScalar::ScalarAccess access;
		PkgLarScalar::ScalarData scalar;
		PkgLarScalar::ScalarData expected;
	} TestRecord;

	logic clk;
	logic reset;
	logic writeStrobe;
	PkgLarScalar::WriteRequest writeReq;
	logic readStrobe;
	PkgLarScalar::ScalarAccess readAccess;
	logic readValid;
	PkgLarScalar::ScalarData readData;

	logic [63:0] words [NumRecords * FieldsPerRecord];

	// reads in flight, oldest first
	PkgLarScalar::ScalarData expectedQueue [$];
	string nameQueue [$];

	// strobe seen half a cycle ago, so valid is due at this edge
	logic validDue = 1'b0;

	int readsIssued = 0;
	int validCount = 0;
	int valueErrors = 0;
	int otherErrors = 0;

	LarScalarAccess
	#(
		.numLars(8)
	)
	i_dut
	(
		.clk(clk),
		.reset(reset),
		.writeStrobe(writeStrobe),
		.writeReq(writeReq),
		.readStrobe(readStrobe),
		.readAccess(readAccess),
		.readValid(readValid),
		.readData(readData)
	);

	always #(ClockPeriod / 2) clk = ~clk;

	function automatic TestRecord recordAt(int index);
		TestRecord rec;
		int base;
		base = index * FieldsPerRecord;
		rec.op = words[base][1:0];
		rec.access.larIndex = words[base + 1][2:0];
		rec.access.dataType = PkgLarScalar::DataType'(words[base + 2][1:0]);
		rec.access.intTypeSize = PkgLarScalar::IntTypeSize'(words[base + 3][1:0]);
		rec.access.dataOffset = words[base + 4][4:0];
		rec.scalar = words[base + 5];
		rec.expected = words[base + 6];
		return rec;
	endfunction

	task automatic checkScalar(string testName, PkgLarScalar::ScalarData expected,
		PkgLarScalar::ScalarData actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected %h actual %h", testName, expected, actual);
			valueErrors++;
		end
	endtask

	task automatic checkValidCount(string testName, int expected, int actual);
		if (actual != expected)
		begin
			$display("[ERROR] %s expected %0d actual %0d", testName, expected, actual);
			valueErrors++;
		end
	endtask

	// results are stable by the falling edge
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (readValid !== validDue)
			begin
				$display("readValid was %b one cycle after readStrobe was %b",
					readValid, validDue);
				otherErrors++;
			end
			if (readValid)
			begin
				validCount++;
				if (expectedQueue.size() == 0)
				begin
					$display("readValid was high with no read outstanding");
					otherErrors++;
				end
				else
				begin
					checkScalar(nameQueue.pop_front(), expectedQueue.pop_front(), readData);
				end
			end
		end
		validDue = readStrobe;
	end

	initial
	begin
		TestRecord rec;
		clk = 1'b0;
		reset = 1'b1;
		writeStrobe = 1'b0;
		writeReq = '0;
		readStrobe = 1'b0;
		readAccess = '0;
		$readmemh("sim/larScalarTestdata.txt", words);
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < NumRecords; i++)
		begin
			@(posedge clk);
			rec = recordAt(i);
			// op 2 writes and reads the same lane in one cycle
			writeStrobe <= (rec.op != 2'd1);
			readStrobe <= (rec.op != 2'd0);
			writeReq.access <= rec.access;
			writeReq.scalar <= rec.scalar;
			readAccess <= rec.access;
			if (rec.op != 2'd0)
			begin
				expectedQueue.push_back(rec.expected);
				nameQueue.push_back($sformatf("record %0d lar %0d offset %0d",
					i, rec.access.larIndex, rec.access.dataOffset));
				readsIssued++;
			end
		end
		@(posedge clk);
		writeStrobe <= 1'b0;
		readStrobe <= 1'b0;
		wait (validCount == readsIssued);
		// a few more cycles to catch stray valid pulses
		repeat (3) @(posedge clk);
		checkValidCount("readValid pulse count", readsIssued, validCount);
		$display("closing: %0d value errors, %0d other errors", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0)
		begin
			$display("*** TEST PASSED ***");
		end
		else
		begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog, sized from the record count
	initial
	begin
		#((NumRecords + 20) * ClockPeriod);
		$display("run timed out before all reads came back");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/larScalarTestdata.txt */
// columns: op lar dataType intTypeSize dataOffset scalar expected, all hex
// op 0 write, 1 read, 2 write and read of the same lane in one cycle
1 0 0 3 00 0000000000000000 0000000000000000
1 1 0 3 00 0000000000000000 0000000000000000
1 2 0 3 00 0000000000000000 0000000000000000
1 3 0 3 00 0000000000000000 0000000000000000
1 4 0 3 00 0000000000000000 0000000000000000
1 5 0 3 00 0000000000000000 0000000000000000
1 6 0 3 00 0000000000000000 0000000000000000
1 7 0 3 00 0000000000000000 0000000000000000
0 1 0 3 18 1122334455667788 0000000000000000
0 1 0 2 10 deadbeefcafef00d 0000000000000000
0 1 0 1 14 000000000000abcd 0000000000000000
0 1 0 0 16 000000000000005a 0000000000000000
1 1 0 3 18 0000000000000000 1122334455667788
1 1 0 3 10 0000000000000000 005aabcdcafef00d
1 1 0 2 10 0000000000000000 00000000cafef00d
1 1 0 0 16 0000000000000000 000000000000005a
1 1 0 1 14 0000000000000000 000000000000abcd
1 1 1 0 13 0000000000000000 00000000000000ca
0 2 0 2 06 0000000087654321 0000000000000000
1 2 0 2 04 0000000000000000 0000000087654321
1 2 0 3 00 0000000000000000 8765432100000000
1 2 0 1 07 0000000000000000 0000000000008765
0 3 2 0 0b ffffffffffff3f80 0000000000000000
1 3 2 0 0a 0000000000000000 0000000000003f80
1 3 0 3 08 0000000000000000 000000003f800000
0 3 3 0 08 ffffffffffffffff 0000000000000000
1 3 0 3 08 0000000000000000 000000003f800000
1 3 3 0 0a 0000000000000000 0000000000000000
2 1 0 2 10 000000000badf00d 00000000cafef00d
1 1 0 2 10 0000000000000000 000000000badf00d
1 1 0 1 12 0000000000000000 0000000000000bad
1 1 0 0 11 0000000000000000 00000000000000f0
1 2 0 0 05 0000000000000000 0000000000000043
1 0 0 3 18 0000000000000000 0000000000000000
0 7 0 3 00 0123456789abcdef 0000000000000000
1 7 0 3 01 0000000000000000 0123456789abcdef
